//--- fir_pkg.sv
/*
 * Shared widths, pipeline depths and types of the 21-tap symmetric FIR.
 * Coefficients are constants. There is no reload path.
 * All sums wrap to SAMPLE_W bits. Products are scaled by SCALE_SHIFT.
 */
package fir_pkg;

	// ************************************************************
	// widths and depths
	// ************************************************************

	// sample, coefficient and sum width
	localparam int SAMPLE_W = 18;

	// filter length, odd so there is one center tap
	localparam int NUM_TAPS = 21;

	// unique coefficients of a symmetric filter
	localparam int NUM_PAIRS = (NUM_TAPS + 1) / 2;

	// arithmetic shift applied to every full product
	localparam int SCALE_SHIFT = 17;

	// registered adder levels from NUM_PAIRS words down to one
	localparam int TREE_LEVELS = 4;

	// words left after each of the first three tree levels
	localparam int TREE_W1 = (NUM_PAIRS + 1) / 2;
	localparam int TREE_W2 = (TREE_W1 + 1) / 2;
	localparam int TREE_W3 = (TREE_W2 + 1) / 2;

	// delay line, then pre-add and multiply, then the tree
	localparam int VALID_DEPTH = 1 + 2 + TREE_LEVELS;

	// ************************************************************
	// types
	// ************************************************************

	// one sample or one wrapped sum
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// full signed product of two samples
	typedef logic signed [2*SAMPLE_W-1:0] product_t;

	// mirrored taps sharing one coefficient
	// near is tap k, far is tap NUM_TAPS-1-k
	typedef struct packed {
		sample_t near;
		sample_t far;
	} tap_pair_t;

	// ************************************************************
	// coefficients
	// ************************************************************

	// index k serves taps k and NUM_TAPS-1-k
	// the center pair adds tap 10 to itself, so the last entry is half of -420
	localparam sample_t COEFF_TABLE [NUM_PAIRS] = '{
		18'sd88,
		18'sd0,
		-18'sd97,
		-18'sd197,
		-18'sd294,
		-18'sd380,
		-18'sd447,
		-18'sd490,
		-18'sd504,
		-18'sd481,
		-18'sd210
	};

endpackage

//--- fir_delay_line.sv
/*
 * Input sample shift register of NUM_TAPS words, grouped as mirrored pairs.
 * A sample is shifted in on every enabled edge, whatever i_valid is.
 * o_valid is i_valid delayed by VALID_DEPTH enabled edges.
 */
`timescale 1ns/1ps

module fir_delay_line
	import fir_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      i_clk_ena,
	input  logic      i_valid,
	input  sample_t   i_sample,
	output tap_pair_t o_pairs [NUM_PAIRS],
	output logic      o_valid
);

	// tap 0 holds the newest sample
	sample_t taps_q [NUM_TAPS];

	logic [VALID_DEPTH-1:0] valid_q;

	// ************************************************************
	// sample shift register
	// ************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NUM_TAPS; i++) begin
				taps_q[i] <= '0;
			end
		end else if (i_clk_ena) begin
			taps_q[0] <= i_sample;
			for (int i = 1; i < NUM_TAPS; i++) begin
				taps_q[i] <= taps_q[i-1];
			end
		end
	end

	// mirrored grouping, the center pair sees tap 10 twice
	for (genvar k = 0; k < NUM_PAIRS; k++) begin : g_pair
		assign o_pairs[k] = '{near: taps_q[k], far: taps_q[NUM_TAPS-1-k]};
	end

	// ************************************************************
	// valid delay
	// ************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= '0;
		end else if (i_clk_ena) begin
			valid_q <= {valid_q[VALID_DEPTH-2:0], i_valid};
		end
	end

	// lines up with the tree output of the same window
	assign o_valid = valid_q[VALID_DEPTH-1];

endmodule

//--- fir_tap_slice.sv
/*
 * One symmetric tap. Registered pre-add of the pair, then a registered
 * scaled multiply by COEFF_TABLE[TAP_INDEX]. TAP_INDEX must be below NUM_PAIRS.
 * Latency is two enabled edges.
 */
`timescale 1ns/1ps

module fir_tap_slice
	import fir_pkg::*;
#(
	parameter int TAP_INDEX = 0
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      i_clk_ena,
	input  tap_pair_t i_pair,
	output sample_t   o_product
);

	// wrapped sum of the mirrored taps
	sample_t pre_sum_q;

	// full product before scaling
	product_t full_product;

	// stage 1, pre-add wraps to SAMPLE_W bits
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pre_sum_q <= '0;
		end else if (i_clk_ena) begin
			pre_sum_q <= i_pair.near + i_pair.far;
		end
	end

	// operands sign extended so no product bit is lost
	assign full_product = product_t'(pre_sum_q) * product_t'(COEFF_TABLE[TAP_INDEX]);

	// stage 2
	// arithmetic shift, then keep the low SAMPLE_W bits
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_product <= '0;
		end else if (i_clk_ena) begin
			o_product <= sample_t'(full_product >>> SCALE_SHIFT);
		end
	end

endmodule

//--- fir_adder_tree.sv
/*
 * Registered binary adder tree, NUM_PAIRS words to one in TREE_LEVELS levels.
 * The fixed level structure holds for 9 to 16 input words.
 * Every add wraps to SAMPLE_W bits. Latency is four enabled edges.
 */
`timescale 1ns/1ps

module fir_adder_tree
	import fir_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    i_clk_ena,
	input  sample_t i_products [NUM_PAIRS],
	output sample_t o_sum
);

	// partial sums after each level
	sample_t lvl1_q [TREE_W1];
	sample_t lvl2_q [TREE_W2];
	sample_t lvl3_q [TREE_W3];

	// ************************************************************
	// level 1
	// ************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < TREE_W1; i++) begin
				lvl1_q[i] <= '0;
			end
		end else if (i_clk_ena) begin
			for (int i = 0; i < NUM_PAIRS / 2; i++) begin
				lvl1_q[i] <= i_products[2*i] + i_products[2*i+1];
			end
			// odd word only gets a register
			if (NUM_PAIRS % 2 != 0) begin
				lvl1_q[TREE_W1-1] <= i_products[NUM_PAIRS-1];
			end
		end
	end

	// ************************************************************
	// level 2
	// ************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < TREE_W2; i++) begin
				lvl2_q[i] <= '0;
			end
		end else if (i_clk_ena) begin
			for (int i = 0; i < TREE_W1 / 2; i++) begin
				lvl2_q[i] <= lvl1_q[2*i] + lvl1_q[2*i+1];
			end
			if (TREE_W1 % 2 != 0) begin
				lvl2_q[TREE_W2-1] <= lvl1_q[TREE_W1-1];
			end
		end
	end

	// ************************************************************
	// level 3
	// ************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < TREE_W3; i++) begin
				lvl3_q[i] <= '0;
			end
		end else if (i_clk_ena) begin
			for (int i = 0; i < TREE_W2 / 2; i++) begin
				lvl3_q[i] <= lvl2_q[2*i] + lvl2_q[2*i+1];
			end
			// with 11 inputs this carries the center tap product
			if (TREE_W2 % 2 != 0) begin
				lvl3_q[TREE_W3-1] <= lvl2_q[TREE_W2-1];
			end
		end
	end

	// ************************************************************
	// level 4, final sum
	// ************************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_sum <= '0;
		end else if (i_clk_ena) begin
			o_sum <= lvl3_q[0] + lvl3_q[1];
		end
	end

endmodule

//--- fir_top.sv
/*
 * 21-tap symmetric FIR for signed 18-bit samples, seven enabled edges deep.
 * i_clk_ena low freezes every register. There is no other back-pressure.
 * o_valid marks outputs whose newest sample was valid.
 */
`timescale 1ns/1ps

module fir_top
	import fir_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    i_clk_ena,
	input  logic    i_valid,
	input  sample_t i_sample,
	output logic    o_valid,
	output sample_t o_sample
);

	// mirrored tap pairs from the delay line
	tap_pair_t pairs [NUM_PAIRS];

	// scaled products, one per unique coefficient
	sample_t products [NUM_PAIRS];

	// ************************************************************
	// input delay line and valid delay
	// ************************************************************
	fir_delay_line u_delay (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_sample  (i_sample),
		.o_pairs   (pairs),
		.o_valid   (o_valid)
	);

	// ************************************************************
	// tap slices
	// ************************************************************

	// slice k serves taps k and NUM_TAPS-1-k
	// the last slice is the center tap
	for (genvar k = 0; k < NUM_PAIRS; k++) begin : g_tap
		fir_tap_slice #(
			.TAP_INDEX (k)
		) u_slice (
			.clk       (clk),
			.reset     (reset),
			.i_clk_ena (i_clk_ena),
			.i_pair    (pairs[k]),
			.o_product (products[k])
		);
	end

	// ************************************************************
	// adder tree
	// ************************************************************
	fir_adder_tree u_tree (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_products (products),
		.o_sum      (o_sample)
	);

endmodule

//--- fir_assert.sv
/*
 * Concurrent checks on the fir_top outputs, attached by bind.
 * Outputs hold on disabled edges and stay cleared while reset is high.
 */
`timescale 1ns/1ps

module fir_assert
	import fir_pkg::*;
(
	input logic    clk,
	input logic    reset,
	input logic    i_clk_ena,
	input logic    i_out_valid,
	input sample_t i_out_sample
);

	// a disabled edge leaves the outputs as they were
	hold_when_disabled: assert property (
		@(posedge clk) disable iff (reset)
		!i_clk_ena |=> ($stable(i_out_valid) && $stable(i_out_sample))
	) else $error("outputs changed on an edge with the clock enable low");

	valid_low_in_reset: assert property (
		@(posedge clk) reset |-> !i_out_valid
	) else $error("o_valid high during reset");

	sample_zero_in_reset: assert property (
		@(posedge clk) reset |-> (i_out_sample == '0)
	) else $error("o_sample not zero during reset");

endmodule

bind fir_top fir_assert u_assert (
	.clk          (clk),
	.reset        (reset),
	.i_clk_ena    (i_clk_ena),
	.i_out_valid  (o_valid),
	.i_out_sample (o_sample)
);

//--- fir_tb.sv
/*
 * Testbench for fir_top. Random samples, valid and clock enable from an xorshift
 * generator, checked on every edge against a model of the filter arithmetic.
 * The impulse is 2**15 so the center pair sum cannot wrap. Stops at the first error.
 */
`timescale 1ns/1ps

module fir_tb
	import fir_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 5;
	localparam int IMPULSE_CYCLES = 60;
	localparam int RANDOM_CYCLES = 2000;
	localparam int MARGIN_CYCLES = 200;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + IMPULSE_CYCLES + RANDOM_CYCLES
		+ MARGIN_CYCLES;

	localparam sample_t IMPULSE = 18'sd32768;

	// whole 21-tap response with the center coefficient not halved
	localparam sample_t FULL_COEFF [NUM_TAPS] = '{
		18'sd88, 18'sd0, -18'sd97, -18'sd197, -18'sd294, -18'sd380, -18'sd447,
		-18'sd490, -18'sd504, -18'sd481, -18'sd420, -18'sd481, -18'sd504,
		-18'sd490, -18'sd447, -18'sd380, -18'sd294, -18'sd197, -18'sd97,
		18'sd0, 18'sd88
	};

	logic    clk;
	logic    reset;
	logic    i_clk_ena;
	logic    i_valid;
	sample_t i_sample;
	logic    o_valid;
	sample_t o_sample;

	logic [31:0] rng_state;
	int          fail_count;

	// model state where hist[0] is the newest sample
	sample_t hist [NUM_TAPS];
	logic    exp_valid_q [$];
	sample_t exp_sample_q [$];
	logic    exp_valid;
	sample_t exp_sample;

	fir_top uut (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_sample  (i_sample),
		.o_valid   (o_valid),
		.o_sample  (o_sample)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout, the test did not finish in %0d cycles", WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	// ************************************************************
	// model
	// ************************************************************
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// full signed product then arithmetic shift and truncation
	function automatic sample_t scaled_product(input sample_t a, input sample_t b);
		longint full;
		full = longint'(a) * longint'(b);
		return sample_t'(full >>> SCALE_SHIFT);
	endfunction

	// wrapped sum over the mirrored pairs of the current window
	function automatic sample_t window_output();
		sample_t acc;
		sample_t pair_sum;
		acc = '0;
		for (int k = 0; k < NUM_PAIRS; k++) begin
			pair_sum = hist[k] + hist[NUM_TAPS-1-k];
			acc = acc + scaled_product(pair_sum, COEFF_TABLE[k]);
		end
		return acc;
	endfunction

	task automatic model_step(input logic vld, input sample_t smp);
		for (int i = NUM_TAPS - 1; i > 0; i--) begin
			hist[i] = hist[i-1];
		end
		hist[0] = smp;
		exp_valid_q.push_back(vld);
		exp_sample_q.push_back(window_output());
		exp_valid = exp_valid_q.pop_front();
		exp_sample = exp_sample_q.pop_front();
	endtask

	// ************************************************************
	// checks and stimulus
	// ************************************************************
	task automatic check_value(input string name, input logic [SAMPLE_W-1:0] actual,
		input logic [SAMPLE_W-1:0] expected);
		if (actual !== expected) begin
			fail_count++;
			$display("[FAIL] %s actual 0x%h expected 0x%h", name, actual, expected);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// drives 1 ns after a rising edge and checks 1 ns after the next one
	task automatic run_cycle(input logic ena, input logic vld, input sample_t smp);
		i_clk_ena = ena;
		i_valid = vld;
		i_sample = smp;
		@(posedge clk);
		if (ena) begin
			model_step(vld, smp);
		end
		#1;
		check_value("o_valid", SAMPLE_W'(o_valid), SAMPLE_W'(exp_valid));
		check_value("o_sample", o_sample, exp_sample);
	endtask

	// one valid impulse amid zeros walks out the coefficient sequence
	task automatic impulse_test();
		for (int i = 0; i < NUM_TAPS + VALID_DEPTH; i++) begin
			run_cycle(1'b1, 1'b0, '0);
		end
		run_cycle(1'b1, 1'b1, IMPULSE);
		for (int i = 1; i < VALID_DEPTH - 1; i++) begin
			run_cycle(1'b1, 1'b0, '0);
		end
		for (int t = 0; t < NUM_TAPS; t++) begin
			run_cycle(1'b1, 1'b0, '0);
			check_value("o_sample impulse", o_sample, scaled_product(IMPULSE, FULL_COEFF[t]));
			if (t == 0) begin
				check_value("o_valid impulse", SAMPLE_W'(o_valid), SAMPLE_W'(1'b1));
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		i_clk_ena = 1'b0;
		i_valid = 1'b0;
		i_sample = '0;
		rng_state = 32'h14b9_c0ec;
		fail_count = 0;
		exp_valid = 1'b0;
		exp_sample = '0;
		for (int i = 0; i < NUM_TAPS; i++) begin
			hist[i] = '0;
		end
		// outputs of the cleared pipeline
		for (int i = 0; i < VALID_DEPTH - 1; i++) begin
			exp_valid_q.push_back(1'b0);
			exp_sample_q.push_back('0);
		end

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		check_value("o_valid after reset", SAMPLE_W'(o_valid), SAMPLE_W'(1'b0));
		check_value("o_sample after reset", o_sample, '0);

		impulse_test();

		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			rng_state = xorshift32(rng_state);
			run_cycle(rng_state[26:24] != 3'd0, rng_state[21:20] != 2'd0,
				sample_t'(rng_state[17:0]));
		end

		if (fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- src.f
fir_pkg.sv
fir_delay_line.sv
fir_tap_slice.sv
fir_adder_tree.sv
fir_top.sv
fir_assert.sv
fir_tb.sv

//--- Makefile
SIM := obj_dir/Vfir_tb
SRCS := fir_pkg.sv fir_delay_line.sv fir_tap_slice.sv fir_adder_tree.sv fir_top.sv \
	fir_assert.sv fir_tb.sv

.PHONY: run lint clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; \
	fi

$(SIM): src.f $(SRCS)
	verilator --binary --timing --assert -f src.f --top-module fir_tb -o Vfir_tb

lint:
	verilator --lint-only -Wall --timing --assert -f src.f --top-module fir_tb

clean:
	rm -rf obj_dir sim.log
